//--- common/data_io_pkg.sv
`default_nettype none

package data_io_pkg;

	// ********************
	// widths
	// ********************

	// one serial byte
	localparam int byte_width = 8;

	// bit position counter inside a byte, counts 0..7 and wraps
	localparam int bit_cnt_width = 3;

	// external memory address
	localparam int addr_width = 25;

	// menu entry the file was picked from
	localparam int index_width = 5;

	// first downloaded byte lands here
	localparam logic [addr_width-1:0] load_base = 25'h0074000;

	// ********************
	// commands
	// ********************

	// opcodes sent as the first byte of a selection
	typedef enum logic [byte_width-1:0] {
		cmd_file_tx     = 8'h53,
		cmd_file_tx_dat = 8'h54,
		cmd_file_index  = 8'h55
	} upload_cmd_t;

	// ********************
	// shared structs
	// ********************

	// byte from the serial receiver
	// first marks the command byte of a selection
	typedef struct packed {
		logic [byte_width-1:0] data;
		logic                  first;
	} spi_byte_t;

	// memory write payload, valid while wr is high
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [byte_width-1:0] data;
	} ram_wr_t;

endpackage

`default_nettype wire

//--- spi_client/spi_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx (
	input  logic                  clk,
	input  logic                  ss,
	// serial link from the host, asynchronous to clk
	input  logic                  spi_sel,
	input  logic                  sck,
	input  logic                  sdi,
	// one-cycle strobe with the completed byte
	output logic                  rx_valid,
	output data_io_pkg::spi_byte_t rx_byte
);

	// ********************
	// input synchronizers
	// ********************

	// two flops per serial input, bit 1 is the synchronized copy
	logic [1:0] sel_sync;
	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;

	// previous synchronized levels for edge detection
	logic sck_prev;
	logic sel_prev;

	// registered sck rising edge, one cycle after the sync output
	logic sck_rise;

	// sdi sample aligned with sck_rise
	logic sdi_bit;

	// ********************
	// byte assembly
	// ********************

	// bit position in the current byte
	logic [data_io_pkg::bit_cnt_width-1:0] bit_cnt;

	// first seven bits, the eighth is taken straight from sdi_bit
	logic [data_io_pkg::byte_width-2:0] shift;

	// pending command byte flag, set when spi_sel rises
	logic first_pend;

	// sel rising edge after synchronization
	logic sel_rise;

	// last bit of a byte arrives with this edge
	logic last_bit;

	assign sel_rise = sel_sync[1] & ~sel_prev;
	assign last_bit = sck_rise & sel_sync[1] &
		(bit_cnt == {data_io_pkg::bit_cnt_width{1'b1}});

	// control path
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			sel_sync   <= '0;
			sck_sync   <= '0;
			sdi_sync   <= '0;
			sck_prev   <= 1'b0;
			sel_prev   <= 1'b0;
			sck_rise   <= 1'b0;
			sdi_bit    <= 1'b0;
			bit_cnt    <= '0;
			first_pend <= 1'b0;
			rx_valid   <= 1'b0;
		end else begin
			sel_sync <= {sel_sync[0], spi_sel};
			sck_sync <= {sck_sync[0], sck};
			sdi_sync <= {sdi_sync[0], sdi};

			sck_prev <= sck_sync[1];
			sel_prev <= sel_sync[1];

			// edges only count while selected
			sck_rise <= sck_sync[1] & ~sck_prev & sel_sync[1];
			sdi_bit  <= sdi_sync[1];

			// strobe defaults low
			rx_valid <= 1'b0;

			if (!sel_sync[1]) begin
				// deselect drops any partial byte
				bit_cnt <= '0;
			end else if (sck_rise) begin
				// wraps from 7 back to 0
				bit_cnt <= bit_cnt + 1'b1;
			end

			if (last_bit) begin
				rx_valid   <= 1'b1;
				first_pend <= 1'b0;
			end

			// new selection, next byte is a command
			// placed last so it wins over the clear above
			if (sel_rise) begin
				first_pend <= 1'b1;
			end
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (sck_rise && sel_sync[1]) begin
			// msb first
			shift <= {shift[data_io_pkg::byte_width-3:0], sdi_bit};
		end
		if (last_bit) begin
			rx_byte.data  <= {shift, sdi_bit};
			rx_byte.first <= first_pend;
		end
	end

endmodule

`default_nettype wire

//--- spi_client/upload_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module upload_decoder (
	input  logic                                  clk,
	input  logic                                  ss,
	// byte stream from the serial receiver
	input  logic                                  rx_valid,
	input  data_io_pkg::spi_byte_t                rx_byte,
	// memory write port, no back-pressure
	output logic                                  wr,
	output data_io_pkg::ram_wr_t                  ram,
	// status levels
	output logic                                  downloading,
	output logic [data_io_pkg::index_width-1:0]   index
);

	// ********************
	// command register
	// ********************

	// opcode of the current selection
	// unknown values are kept so their payload is ignored
	data_io_pkg::upload_cmd_t cmd;

	// ********************
	// byte classification
	// ********************

	// first byte of a selection
	logic is_cmd;

	// payload byte under each known command
	logic is_tx;
	logic is_dat;
	logic is_idx;

	// file transfer start request, bit 0 of the payload
	logic tx_start;

	always_comb begin
		is_cmd = rx_valid & rx_byte.first;
		is_tx  = 1'b0;
		is_dat = 1'b0;
		is_idx = 1'b0;
		if (rx_valid && !rx_byte.first) begin
			case (cmd)
				data_io_pkg::cmd_file_tx: begin
					is_tx = 1'b1;
				end
				data_io_pkg::cmd_file_tx_dat: begin
					is_dat = 1'b1;
				end
				data_io_pkg::cmd_file_index: begin
					is_idx = 1'b1;
				end
				default: begin
					// other opcodes drop their payload
					is_tx = 1'b0;
				end
			endcase
		end
		tx_start = is_tx & rx_byte.data[0];
	end

	// ********************
	// address and state
	// ********************

	// address of the last byte written
	logic [data_io_pkg::addr_width-1:0] addr_q;

	// byte for the pending write
	logic [data_io_pkg::byte_width-1:0] data_q;

	// address before load_base so the first write hits load_base
	logic [data_io_pkg::addr_width-1:0] addr_init;

	assign addr_init = data_io_pkg::load_base - 1'b1;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			cmd         <= data_io_pkg::cmd_file_tx;
			wr          <= 1'b0;
			downloading <= 1'b0;
			index       <= '0;
			addr_q      <= addr_init;
		end else begin
			// write strobe lasts one cycle
			wr <= 1'b0;

			if (is_cmd) begin
				cmd <= data_io_pkg::upload_cmd_t'(rx_byte.data);
			end

			// start or end of a download
			if (is_tx) begin
				downloading <= rx_byte.data[0];
			end

			// a start rewinds the address counter
			if (tx_start) begin
				addr_q <= addr_init;
			end

			// data byte goes to the next address
			// written even when no download is active
			if (is_dat) begin
				addr_q <= addr_q + 1'b1;
				wr     <= 1'b1;
			end

			// menu entry of the file
			if (is_idx) begin
				index <= rx_byte.data[data_io_pkg::index_width-1:0];
			end
		end
	end

	// write data, only meaningful with wr
	always_ff @(posedge clk) begin
		if (is_dat) begin
			data_q <= rx_byte.data;
		end
	end

	// ********************
	// memory port
	// ********************

	// address and data change together with wr
	assign ram.addr = addr_q;
	assign ram.data = data_q;

endmodule

`default_nettype wire

//--- src/data_io.sv
`timescale 1ns/1ps
`default_nettype none

module data_io (
	input  logic                                clk,
	input  logic                                ss,
	// serial link from the host controller
	// spi_sel high means selected
	input  logic                                spi_sel,
	input  logic                                sck,
	input  logic                                sdi,
	// external memory write port
	output logic                                wr,
	output data_io_pkg::ram_wr_t                ram,
	// download status
	output logic                                downloading,
	// menu index of the loaded file
	output logic [data_io_pkg::index_width-1:0] index
);

	// ********************
	// internal wires
	// ********************

	// byte strobe between receiver and decoder
	logic rx_valid;

	// received byte with the command flag
	data_io_pkg::spi_byte_t rx_byte;

	// ********************
	// serial receiver
	// ********************

	// oversamples sck on clk and assembles bytes
	spi_byte_rx i_spi_byte_rx (
		.clk      (clk),
		.ss       (ss),
		.spi_sel  (spi_sel),
		.sck      (sck),
		.sdi      (sdi),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	// ********************
	// command decoder
	// ********************

	// runs the download state and drives the memory writes
	upload_decoder i_upload_decoder (
		.clk         (clk),
		.ss          (ss),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.wr          (wr),
		.ram         (ram),
		.downloading (downloading),
		.index       (index)
	);

endmodule

`default_nettype wire

//--- tests/spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host (
	input  logic clk,
	// serial link towards the DUT
	output logic spi_sel,
	output logic sck,
	output logic sdi
);

	// sck high and low time in clk cycles
	localparam int half_period = 4;

	// idle link at time zero
	initial begin
		spi_sel <= 1'b0;
		sck     <= 1'b0;
		sdi     <= 1'b0;
	end

	// ********************
	// bit level
	// ********************

	// sdi changes while sck is low, DUT samples on the rising edge
	task automatic drive_bit(input logic b);
		sck <= 1'b0;
		sdi <= b;
		repeat (half_period) @(posedge clk);
		sck <= 1'b1;
		repeat (half_period) @(posedge clk);
	endtask

	// msb first, n may be less than 8 for a cut byte
	task automatic send_bits(input logic [7:0] b, input int n);
		int i;
		for (i = 7; i > 7 - n; i--) begin
			drive_bit(b[i]);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		send_bits(b, 8);
	endtask

	// ********************
	// selection framing
	// ********************

	// raise spi_sel with sck parked low
	task automatic start_selection();
		@(posedge clk);
		spi_sel <= 1'b1;
		sck     <= 1'b0;
		repeat (half_period) @(posedge clk);
	endtask

	// park sck low first so no edge is seen while spi_sel falls
	task automatic end_selection();
		@(posedge clk);
		sck <= 1'b0;
		repeat (half_period) @(posedge clk);
		spi_sel <= 1'b0;
		repeat (2 * half_period) @(posedge clk);
	endtask

endmodule

`default_nettype wire

//--- tests/tb_data_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_io;

	localparam int num_rows      = 13;
	localparam int write_timeout = 400;

	// one row of the stimulus table
	// payload[0] is sent first, rnd asks for 1..16 random bytes
	// cut sends that many bits of a partial byte before spi_sel drops
	typedef struct packed {
		logic [7:0]      cmd;
		logic [4:0]      len;
		logic            rnd;
		logic [3:0][7:0] payload;
		logic [2:0]      cut;
		logic            exp_dl;
		logic [4:0]      exp_idx;
	} row_t;

	logic clk;
	logic ss;
	logic spi_sel;
	logic sck;
	logic sdi;
	logic wr;
	data_io_pkg::ram_wr_t ram;
	logic downloading;
	logic [data_io_pkg::index_width-1:0] index;

	row_t rows [num_rows];

	// writes seen on the port and writes the model predicts
	data_io_pkg::ram_wr_t got_q [$];
	data_io_pkg::ram_wr_t exp_q [$];

	// model address of the last byte written
	logic [data_io_pkg::addr_width-1:0] m_addr;

	int errors;
	int passed;
	int failed;

	// ********************
	// clock, DUT and host
	// ********************

	initial clk = 1'b0;
	always #10 clk = ~clk;

	data_io i_data_io (
		.clk         (clk),
		.ss          (ss),
		.spi_sel     (spi_sel),
		.sck         (sck),
		.sdi         (sdi),
		.wr          (wr),
		.ram         (ram),
		.downloading (downloading),
		.index       (index)
	);

	spi_host i_host (
		.clk     (clk),
		.spi_sel (spi_sel),
		.sck     (sck),
		.sdi     (sdi)
	);

	// capture every write cycle
	always @(posedge clk) begin
		if (wr) begin
			got_q.push_back(ram);
		end
	end

	function automatic row_t make_row(input logic [7:0] cmd, input logic [4:0] len,
		input logic rnd, input logic [31:0] payload, input logic [2:0] cut,
		input logic exp_dl, input logic [4:0] exp_idx);
		row_t r;
		r.cmd     = cmd;
		r.len     = len;
		r.rnd     = rnd;
		r.payload = payload;
		r.cut     = cut;
		r.exp_dl  = exp_dl;
		r.exp_idx = exp_idx;
		return r;
	endfunction

	// ********************
	// reference model
	// ********************

	// file-data bytes go to the next address, a start rewinds it
	task automatic predict_writes(input logic [7:0] cmd, input logic [7:0] bytes [$]);
		data_io_pkg::ram_wr_t w;
		foreach (bytes[k]) begin
			case (cmd)
				data_io_pkg::cmd_file_tx: begin
					if (bytes[k][0]) begin
						m_addr = data_io_pkg::load_base - 25'd1;
					end
				end
				data_io_pkg::cmd_file_tx_dat: begin
					m_addr = m_addr + 25'd1;
					w.addr = m_addr;
					w.data = bytes[k];
					exp_q.push_back(w);
				end
				default: begin
					// index and unknown commands never write
				end
			endcase
		end
	endtask

	// ********************
	// checks
	// ********************

	task automatic check_writes();
		int cyc;
		int k;
		cyc = 0;
		while (got_q.size() < exp_q.size() && cyc < write_timeout) begin
			@(posedge clk);
			cyc++;
		end
		assert (got_q.size() >= exp_q.size()) else begin
			$display("timeout: only %0d of %0d writes arrived", got_q.size(), exp_q.size());
			errors++;
		end
		assert (got_q.size() <= exp_q.size()) else begin
			$display("unexpected writes: %0d seen, %0d expected", got_q.size(), exp_q.size());
			errors++;
		end
		for (k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
			assert (got_q[k].addr === exp_q[k].addr) else begin
				$display("Mismatch ram.addr write %0d: got %07h expected %07h",
					k, got_q[k].addr, exp_q[k].addr);
				errors++;
			end
			assert (got_q[k].data === exp_q[k].data) else begin
				$display("Mismatch ram.data write %0d: got %02h expected %02h",
					k, got_q[k].data, exp_q[k].data);
				errors++;
			end
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic check_status(input logic exp_dl, input logic [4:0] exp_idx);
		@(negedge clk);
		assert (downloading === exp_dl) else begin
			$display("Mismatch downloading: got %h expected %h", downloading, exp_dl);
			errors++;
		end
		assert (index === exp_idx) else begin
			$display("Mismatch index: got %02h expected %02h", index, exp_idx);
			errors++;
		end
	endtask

	// one selection per row, then compare
	task automatic run_row(input int t);
		row_t r;
		logic [7:0] bytes [$];
		int n;
		int k;
		int nw;
		int err0;
		r = rows[t];
		err0 = errors;
		if (r.rnd) begin
			n = 1 + int'($urandom % 16);
			for (k = 0; k < n; k++) begin
				bytes.push_back(8'($urandom));
			end
		end else begin
			n = int'(r.len);
			for (k = 0; k < n; k++) begin
				bytes.push_back(r.payload[k]);
			end
		end
		predict_writes(r.cmd, bytes);
		nw = exp_q.size();
		i_host.start_selection();
		i_host.send_byte(r.cmd);
		for (k = 0; k < n; k++) begin
			i_host.send_byte(bytes[k]);
		end
		if (r.cut != 3'd0) begin
			i_host.send_bits(8'hff, int'(r.cut));
		end
		i_host.end_selection();
		check_writes();
		check_status(r.exp_dl, r.exp_idx);
		if (errors == err0) begin
			passed++;
			$display("test %0d cmd %02h bytes %0d writes %0d: ok", t + 1, r.cmd, n, nw);
		end else begin
			failed++;
			$display("test %0d cmd %02h bytes %0d writes %0d: FAIL", t + 1, r.cmd, n, nw);
		end
	endtask

	// ********************
	// main sequence
	// ********************

	initial begin
		errors = 0;
		passed = 0;
		failed = 0;
		void'($urandom(11400));
		m_addr = data_io_pkg::load_base - 25'd1;
		// cmd len rnd payload(first byte lowest) cut dl idx
		rows[0]  = make_row(8'h53, 5'd1, 1'b0, 32'h00000001, 3'd0, 1'b1, 5'h00);
		rows[1]  = make_row(8'h54, 5'd4, 1'b0, 32'h44332211, 3'd0, 1'b1, 5'h00);
		rows[2]  = make_row(8'h54, 5'd0, 1'b1, 32'h00000000, 3'd0, 1'b1, 5'h00);
		rows[3]  = make_row(8'h53, 5'd1, 1'b0, 32'h00000001, 3'd0, 1'b1, 5'h00);
		rows[4]  = make_row(8'h54, 5'd3, 1'b0, 32'h00ccbbaa, 3'd0, 1'b1, 5'h00);
		rows[5]  = make_row(8'h53, 5'd1, 1'b0, 32'h00000000, 3'd0, 1'b0, 5'h00);
		rows[6]  = make_row(8'h54, 5'd0, 1'b1, 32'h00000000, 3'd0, 1'b0, 5'h00);
		rows[7]  = make_row(8'h55, 5'd1, 1'b0, 32'h0000003a, 3'd0, 1'b0, 5'h1a);
		// unknown opcode, payload looks like commands
		rows[8]  = make_row(8'h42, 5'd3, 1'b0, 32'h00550154, 3'd0, 1'b0, 5'h1a);
		rows[9]  = make_row(8'h54, 5'd2, 1'b0, 32'h0000a55a, 3'd5, 1'b0, 5'h1a);
		rows[10] = make_row(8'h55, 5'd1, 1'b0, 32'h00000007, 3'd0, 1'b0, 5'h07);
		rows[11] = make_row(8'h53, 5'd1, 1'b0, 32'h00000003, 3'd0, 1'b1, 5'h07);
		rows[12] = make_row(8'h54, 5'd0, 1'b1, 32'h00000000, 3'd0, 1'b1, 5'h07);

		ss <= 1'b1;
		repeat (8) @(posedge clk);
		ss <= 1'b0;

		// reset state, nothing written yet
		repeat (16) @(posedge clk);
		check_status(1'b0, 5'h00);
		assert (wr === 1'b0 && got_q.size() == 0) else begin
			$display("write seen during the reset sequence");
			errors++;
		end
		assert (ram.addr === data_io_pkg::load_base - 25'd1) else begin
			$display("Mismatch ram.addr after reset: got %07h expected %07h",
				ram.addr, data_io_pkg::load_base - 25'd1);
			errors++;
		end
		if (errors == 0) begin
			passed++;
			$display("test 0 reset: ok");
		end else begin
			failed++;
			$display("test 0 reset: FAIL");
		end

		for (int t = 0; t < num_rows; t++) begin
			run_row(t);
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			passed + failed, passed, failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
common/data_io_pkg.sv
spi_client/spi_byte_rx.sv
spi_client/upload_decoder.sv
src/data_io.sv
tests/spi_host.sv
tests/tb_data_io.sv

//--- Makefile
# Verilator build and run for the data_io download port

VERILATOR ?= verilator
TOP       ?= tb_data_io
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
BIN       ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

# sources taken from the file list, +incdir+ lines skipped
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails when the log holds the fail message or the binary exits nonzero
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
